/* hw/robPkg.sv */
package robPkg;

    // Buffer geometry, bank indexing in rob assumes these values
    localparam int robLength = 64;
    localparam int robWidth = 4;
    localparam int wbWidth = 4;

    localparam int sqNBits = 7;
    localparam int tagBits = 7;
    localparam int regNmBits = 5;
    localparam int fetchIdBits = 3;
    localparam int fetchOffBits = 4;

    // RISC-V fflags width and commit count width
    localparam int fflagsBits = 5;
    localparam int cntBits = 3;

    // Bit 6 is the wrap bit, bits 5:0 index the entry
    typedef logic [sqNBits-1:0] SqN;
    typedef logic [tagBits-1:0] Tag;
    typedef logic [regNmBits-1:0] RegNm;
    typedef logic [fetchIdBits-1:0] FetchId;
    typedef logic [fetchOffBits-1:0] FetchOff;

    // Order matters, commit compares codes by magnitude
    typedef enum logic [3:0] {
        flagsNone,
        flagsNx,
        flagsBranch,
        flagsFpNx,
        flagsFpUf,
        flagsFpOf,
        flagsFpDz,
        flagsFpNv,
        flagsPredTaken,
        flagsPredNtaken,
        flagsFence,
        flagsTrap,
        flagsIllegalInstr,
        flagsAccessFault
    } Flags;

    typedef enum logic [1:0] {
        fuRn,
        fuTrap,
        fuExec
    } FuType;

    typedef struct packed {
        SqN sqN;
        Tag tagDst;
        RegNm nmDst;
        FuType fu;
        FetchId fetchId;
        FetchOff fetchOffs;
        logic compressed;
    } RenameUOp;

    typedef struct packed {
        logic valid;
        SqN sqN;
        Tag tagDst;
        RegNm nmDst;
        Flags flags;
        logic doNotCommit;
    } ResultUOp;

    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchProv;

    typedef struct packed {
        logic valid;
        SqN sqN;
        Tag tagDst;
        RegNm nmDst;
        logic isBranch;
        logic compressed;
    } CommitUOp;

    typedef struct packed {
        logic valid;
        Flags flags;
        Tag tag;
        SqN sqN;
        RegNm name;
        FetchOff fetchOffs;
        FetchId fetchId;
        logic compressed;
    } TrapUOp;

endpackage

/* hw/robCsrPkg.sv */
package robCsrPkg;

    localparam int wbDataBits = 32;

    // Word addresses of the register block
    typedef enum logic [1:0] {
        csrCtrl,
        csrFflags,
        csrCommitCount,
        csrTrapInfo
    } CsrAddr;

    typedef logic [wbDataBits-1:0] WbData;

    // Master side, held stable until ack
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        CsrAddr adr;
        WbData datW;
    } WbReq;

    typedef struct packed {
        logic ack;
        WbData datR;
    } WbRsp;

endpackage

/* hw/rob.sv */
`timescale 1ns/1ps

module rob
    import robPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  RenameUOp uop[robWidth-1:0],
    input  logic [robWidth-1:0] uopValid,
    input  ResultUOp wbUOps[wbWidth-1:0],
    input  BranchProv branch,
    input  logic commitEnable,
    output SqN maxSqN,
    output SqN curSqN,
    output CommitUOp comUOp[robWidth-1:0],
    output logic [fflagsBits-1:0] fpNewFlags,
    output FetchId curFetchId,
    output TrapUOp trapUOp,
    output logic mispredFlush,
    output logic [cntBits-1:0] commitPulse
);

    typedef struct packed {
        logic valid;
        Flags flags;
        Tag tag;
        logic sqNMsb;
        RegNm name;
        FetchOff fetchOffs;
        FetchId fetchId;
        logic compressed;
    } RobEntry;

    RobEntry entries[robLength-1:0];
    SqN baseIndex;
    logic stop;

    // Replay state after a mispredict
    logic misprReplay;
    logic misprReplayEnd;
    SqN misprReplayIter;
    SqN misprReplayEndSqN;

    RenameUOp sortedUOp[robWidth-1:0];
    logic [robWidth-1:0] sortedValid;
    logic [5:0] enqIdx[robWidth-1:0];

    SqN readBase;
    SqN laneSqN[robWidth-1:0];
    RobEntry deqEntries[robWidth-1:0];

    logic doCommit;
    logic doReplay;
    logic replayLast;

    CommitUOp comNext[robWidth-1:0];
    TrapUOp trapNext;
    logic [fflagsBits-1:0] fpNext;
    logic [cntBits-1:0] cntNext;
    logic [robWidth-1:0] commitMask;
    logic stopNext;
    FetchId fetchIdNext;

    // Wrap-aware age difference, negative means a is older
    function automatic logic signed [sqNBits-1:0] sqNDiff(SqN a, SqN b);
        return $signed(SqN'(a - b));
    endfunction

    function automatic logic isExcept(Flags f);
        return f == flagsTrap || f == flagsIllegalInstr || f == flagsAccessFault;
    endfunction

    function automatic logic isBranchFlag(Flags f);
        return f == flagsBranch || f == flagsPredTaken || f == flagsPredNtaken;
    endfunction

    assign maxSqN = baseIndex + SqN'(robLength - 1);
    assign curSqN = baseIndex;

    // Sort rename lanes into banks by the low sqN bits
    always_comb begin
        for (int b = 0; b < robWidth; b++) begin
            sortedValid[b] = 1'b0;
            sortedUOp[b] = '0;
            for (int j = 0; j < robWidth; j++) begin
                if (uopValid[j] && uop[j].sqN[1:0] == 2'(b)) begin
                    sortedValid[b] = 1'b1;
                    sortedUOp[b] = uop[j];
                end
            end
            enqIdx[b] = {sortedUOp[b].sqN[5:2], 2'(b)};
        end
    end

    // Read window starts at the head, or at the replay pointer
    assign readBase = misprReplay ? misprReplayIter : baseIndex;

    always_comb begin
        for (int i = 0; i < robWidth; i++) begin
            laneSqN[i] = readBase + SqN'(i);
            deqEntries[i] = entries[laneSqN[i][5:0]];
        end
    end

    assign doReplay = misprReplay && !misprReplayEnd && !branch.taken;
    assign doCommit = !misprReplay && !branch.taken && !stop && commitEnable;
    assign replayLast = sqNDiff(misprReplayIter + SqN'(robWidth - 1), misprReplayEndSqN) >= 0;

    always_comb begin
        logic blocked;
        logic pred;
        logic wbHit;
        blocked = 1'b0;
        pred = 1'b0;
        wbHit = 1'b0;
        trapNext = '0;
        fpNext = '0;
        cntNext = '0;
        commitMask = '0;
        stopNext = 1'b0;
        fetchIdNext = curFetchId;
        for (int i = 0; i < robWidth; i++) begin
            comNext[i] = '0;
        end

        if (doReplay) begin
            for (int i = 0; i < robWidth; i++) begin
                if (sqNDiff(laneSqN[i], misprReplayEndSqN) <= 0) begin
                    wbHit = 1'b0;
                    for (int j = 0; j < wbWidth; j++) begin
                        if (wbUOps[j].valid && wbUOps[j].sqN == laneSqN[i]) begin
                            wbHit = 1'b1;
                        end
                    end
                    comNext[i].valid = 1'b1;
                    comNext[i].sqN = laneSqN[i];
                    comNext[i].tagDst = deqEntries[i].tag;
                    comNext[i].nmDst = (deqEntries[i].flags == flagsTrap) ?
                        '0 : deqEntries[i].name;
                    comNext[i].isBranch = isBranchFlag(deqEntries[i].flags);
                    // Result never written, rename must not trust this tag
                    comNext[i].compressed = (deqEntries[i].flags == flagsNx) && !wbHit;
                end
            end
        end else if (doCommit) begin
            for (int i = 0; i < robWidth; i++) begin
                if (!blocked && deqEntries[i].valid && deqEntries[i].flags != flagsNx &&
                        (!pred || deqEntries[i].flags == flagsNone)) begin
                    comNext[i].valid = 1'b1;
                    comNext[i].sqN = laneSqN[i];
                    comNext[i].tagDst = deqEntries[i].tag;
                    comNext[i].nmDst = isExcept(deqEntries[i].flags) ?
                        '0 : deqEntries[i].name;
                    comNext[i].isBranch = isBranchFlag(deqEntries[i].flags);
                    comNext[i].compressed = deqEntries[i].compressed;
                    fetchIdNext = deqEntries[i].fetchId;
                    commitMask[i] = 1'b1;
                    cntNext = cntNext + 3'd1;

                    // Only one trap port op per cycle
                    if (deqEntries[i].flags >= flagsPredTaken) begin
                        trapNext.valid = 1'b1;
                        trapNext.flags = deqEntries[i].flags;
                        trapNext.tag = deqEntries[i].tag;
                        trapNext.sqN = laneSqN[i];
                        trapNext.name = deqEntries[i].name;
                        trapNext.fetchOffs = deqEntries[i].fetchOffs;
                        trapNext.fetchId = deqEntries[i].fetchId;
                        trapNext.compressed = deqEntries[i].compressed;
                        pred = 1'b1;
                        if (deqEntries[i].flags >= flagsFence) begin
                            stopNext = 1'b1;
                            blocked = 1'b1;
                        end
                    end

                    // UF and OF imply inexact
                    case (deqEntries[i].flags)
                        flagsFpNx: fpNext[0] = 1'b1;
                        flagsFpUf: fpNext[1:0] = fpNext[1:0] | 2'b11;
                        flagsFpOf: fpNext[2:0] = fpNext[2:0] | 3'b101;
                        flagsFpDz: fpNext[3] = 1'b1;
                        flagsFpNv: fpNext[4] = 1'b1;
                        default: ;
                    endcase
                end else begin
                    blocked = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            baseIndex <= '0;
            stop <= 1'b0;
            misprReplay <= 1'b0;
            misprReplayEnd <= 1'b0;
            mispredFlush <= 1'b0;
            curFetchId <= '1;
            trapUOp <= '0;
            fpNewFlags <= '0;
            commitPulse <= '0;
            for (int i = 0; i < robWidth; i++) begin
                comUOp[i] <= '0;
            end
            for (int e = 0; e < robLength; e++) begin
                entries[e].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < robWidth; i++) begin
                comUOp[i] <= comNext[i];
                if (commitMask[i]) begin
                    entries[laneSqN[i][5:0]].valid <= 1'b0;
                end
            end
            trapUOp <= trapNext;
            fpNewFlags <= fpNext;
            commitPulse <= cntNext;
            stop <= stopNext;
            curFetchId <= fetchIdNext;
            baseIndex <= baseIndex + SqN'(cntNext);

            if (branch.taken) begin
                // Drop everything younger than the branch
                for (int e = 0; e < robLength; e++) begin
                    if (sqNDiff({entries[e].sqNMsb, 6'(e)}, branch.sqN) > 0) begin
                        entries[e].valid <= 1'b0;
                    end
                end
                misprReplay <= 1'b1;
                misprReplayEnd <= 1'b0;
                misprReplayIter <= baseIndex;
                misprReplayEndSqN <= branch.sqN;
                mispredFlush <= 1'b0;
            end else if (misprReplay) begin
                if (misprReplayEnd) begin
                    // Idle cycle before normal commit resumes
                    misprReplay <= 1'b0;
                    mispredFlush <= 1'b0;
                end else begin
                    mispredFlush <= 1'b1;
                    misprReplayIter <= misprReplayIter + SqN'(robWidth);
                    misprReplayEnd <= replayLast;
                end
            end

            for (int b = 0; b < robWidth; b++) begin
                if (sortedValid[b] && !branch.taken) begin
                    entries[enqIdx[b]].valid <= 1'b1;
                    entries[enqIdx[b]].tag <= sortedUOp[b].tagDst;
                    entries[enqIdx[b]].name <= sortedUOp[b].nmDst;
                    entries[enqIdx[b]].sqNMsb <= sortedUOp[b].sqN[6];
                    entries[enqIdx[b]].fetchOffs <= sortedUOp[b].fetchOffs;
                    entries[enqIdx[b]].fetchId <= sortedUOp[b].fetchId;
                    entries[enqIdx[b]].compressed <= sortedUOp[b].compressed;
                    case (sortedUOp[b].fu)
                        fuRn: entries[enqIdx[b]].flags <= flagsNone;
                        fuTrap: entries[enqIdx[b]].flags <= flagsTrap;
                        default: entries[enqIdx[b]].flags <= flagsNx;
                    endcase
                end
            end

            // Writeback marks completion, wrong-path results are ignored
            for (int p = 0; p < wbWidth; p++) begin
                if (wbUOps[p].valid && !wbUOps[p].doNotCommit &&
                        (!branch.taken || sqNDiff(wbUOps[p].sqN, branch.sqN) <= 0)) begin
                    entries[wbUOps[p].sqN[5:0]].flags <= wbUOps[p].flags;
                end
            end
        end
    end

endmodule

/* hw/robCsr.sv */
`timescale 1ns/1ps

module robCsr
    import robPkg::*;
    import robCsrPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  WbReq wbReq,
    input  logic [fflagsBits-1:0] fpNewFlags,
    input  logic [cntBits-1:0] commitPulse,
    input  TrapUOp trapUOp,
    output WbRsp wbRsp,
    output logic commitEnable
);

    logic access;
    logic writeEn;
    WbData readData;

    logic [fflagsBits-1:0] fflags;
    WbData commitCount;
    SqN trapSqN;
    Flags trapFlags;

    // New cycle seen while ack is low, ack follows one cycle later
    assign access = wbReq.cyc && wbReq.stb && !wbRsp.ack;
    assign writeEn = access && wbReq.we;

    always_comb begin
        readData = '0;
        case (wbReq.adr)
            csrCtrl: readData[0] = commitEnable;
            csrFflags: readData[fflagsBits-1:0] = fflags;
            csrCommitCount: readData = commitCount;
            csrTrapInfo: begin
                readData[6:0] = trapSqN;
                readData[11:8] = trapFlags;
            end
            default: readData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbRsp.ack <= 1'b0;
        end else begin
            wbRsp.ack <= access;
        end
        if (access) begin
            wbRsp.datR <= readData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commitEnable <= 1'b1;
        end else if (writeEn && wbReq.adr == csrCtrl) begin
            commitEnable <= wbReq.datW[0];
        end
    end

    // Sticky flags, a write clears but new hardware flags still land
    always_ff @(posedge clk) begin
        if (rst) begin
            fflags <= '0;
        end else if (writeEn && wbReq.adr == csrFflags) begin
            fflags <= fpNewFlags;
        end else begin
            fflags <= fflags | fpNewFlags;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commitCount <= '0;
        end else begin
            commitCount <= commitCount + WbData'(commitPulse);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            trapSqN <= '0;
            trapFlags <= flagsNone;
        end else if (trapUOp.valid) begin
            trapSqN <= trapUOp.sqN;
            trapFlags <= trapUOp.flags;
        end
    end

endmodule

/* hw/robTop.sv */
`timescale 1ns/1ps

module robTop
    import robPkg::*;
    import robCsrPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  RenameUOp uop[robWidth-1:0],
    input  logic [robWidth-1:0] uopValid,
    input  ResultUOp wbUOps[wbWidth-1:0],
    input  BranchProv branch,
    output SqN maxSqN,
    output SqN curSqN,
    output CommitUOp comUOp[robWidth-1:0],
    output logic [fflagsBits-1:0] fpNewFlags,
    output FetchId curFetchId,
    output TrapUOp trapUOp,
    output logic mispredFlush,
    input  WbReq wbReq,
    output WbRsp wbRsp
);

    logic commitEnable;
    logic [cntBits-1:0] commitPulse;

    rob rob_i (
        .clk(clk),
        .rst(rst),
        .uop(uop),
        .uopValid(uopValid),
        .wbUOps(wbUOps),
        .branch(branch),
        .commitEnable(commitEnable),
        .maxSqN(maxSqN),
        .curSqN(curSqN),
        .comUOp(comUOp),
        .fpNewFlags(fpNewFlags),
        .curFetchId(curFetchId),
        .trapUOp(trapUOp),
        .mispredFlush(mispredFlush),
        .commitPulse(commitPulse)
    );

    // Register block watches the commit stream
    robCsr robCsr_i (
        .clk(clk),
        .rst(rst),
        .wbReq(wbReq),
        .fpNewFlags(fpNewFlags),
        .commitPulse(commitPulse),
        .trapUOp(trapUOp),
        .wbRsp(wbRsp),
        .commitEnable(commitEnable)
    );

endmodule

/* tb/robTop_chk.sv */
`timescale 1ns/1ps

module robTop_chk
    import robPkg::*;
    import robCsrPkg::*;
(
    input logic clk,
    input logic rst,
    input CommitUOp comUOp[robWidth-1:0],
    input TrapUOp trapUOp,
    input logic mispredFlush,
    input WbRsp wbRsp
);

    int failures = 0;

    // Single-cycle ack per bus cycle
    ackPulse: assert property (@(posedge clk) disable iff (rst)
        wbRsp.ack |=> !wbRsp.ack)
        else begin
            $error("wbRsp.ack held high for two cycles");
            failures++;
        end

    // Valid lanes are packed from lane 0
    lanes01: assert property (@(posedge clk) disable iff (rst)
        !comUOp[0].valid |-> !comUOp[1].valid)
        else begin
            $error("commit lane 1 valid with lane 0 empty");
            failures++;
        end
    lanes12: assert property (@(posedge clk) disable iff (rst)
        !comUOp[1].valid |-> !comUOp[2].valid)
        else begin
            $error("commit lane 2 valid with lane 1 empty");
            failures++;
        end
    lanes23: assert property (@(posedge clk) disable iff (rst)
        !comUOp[2].valid |-> !comUOp[3].valid)
        else begin
            $error("commit lane 3 valid with lane 2 empty");
            failures++;
        end

    trapWithCommit: assert property (@(posedge clk) disable iff (rst)
        trapUOp.valid |-> comUOp[0].valid)
        else begin
            $error("trapUOp valid without a commit lane");
            failures++;
        end

    flushNoTrap: assert property (@(posedge clk) disable iff (rst)
        !(mispredFlush && trapUOp.valid))
        else begin
            $error("trapUOp valid during replay");
            failures++;
        end

endmodule

/* tb/robTb.sv */
`timescale 1ns/1ps

module robTb
    import robPkg::*;
    import robCsrPkg::*;
();

    // Ops issued over all tests, sets the run limit
    localparam int plannedOps = 348;
    localparam int cycleLimit = 40 * plannedOps + 200;
    localparam int maxInFlight = 56;

    logic clk;
    logic rst;
    RenameUOp uop[robWidth-1:0];
    logic [robWidth-1:0] uopValid;
    ResultUOp wbUOps[wbWidth-1:0];
    BranchProv branch;
    SqN maxSqN;
    SqN curSqN;
    CommitUOp comUOp[robWidth-1:0];
    logic [fflagsBits-1:0] fpNewFlags;
    FetchId curFetchId;
    TrapUOp trapUOp;
    logic mispredFlush;
    WbReq wbReq;
    WbRsp wbRsp;

    // Reference model of the entry array
    Tag mTag[robLength];
    RegNm mNm[robLength];
    Flags mFlags[robLength];
    logic mComp[robLength];
    FetchId mFid[robLength];
    FetchOff mOffs[robLength];
    int mMode[robLength];
    SqN expQ[$];
    SqN replayQ[$];
    SqN pendWb[$];
    SqN nextSq;
    SqN mHead;
    FetchId lastFid;
    logic fidKnown;
    logic [fflagsBits-1:0] accrued;
    int commits;
    SqN lastTrapSq;
    Flags lastTrapFlags;

    logic [31:0] lcgState;
    int cycles;
    int cmpErrors;
    int otherErrors;

    robTop dut_i (
        .clk(clk),
        .rst(rst),
        .uop(uop),
        .uopValid(uopValid),
        .wbUOps(wbUOps),
        .branch(branch),
        .maxSqN(maxSqN),
        .curSqN(curSqN),
        .comUOp(comUOp),
        .fpNewFlags(fpNewFlags),
        .curFetchId(curFetchId),
        .trapUOp(trapUOp),
        .mispredFlush(mispredFlush),
        .wbReq(wbReq),
        .wbRsp(wbRsp)
    );

    bind robTop robTop_chk chk_i (
        .clk(clk),
        .rst(rst),
        .comUOp(comUOp),
        .trapUOp(trapUOp),
        .mispredFlush(mispredFlush),
        .wbRsp(wbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic signed [6:0] ageDiff(SqN a, SqN b);
        return $signed(SqN'(a - b));
    endfunction

    function automatic logic [4:0] fpMap(Flags f);
        case (f)
            flagsFpNx: return 5'b00001;
            flagsFpUf: return 5'b00011;
            flagsFpOf: return 5'b00101;
            flagsFpDz: return 5'b01000;
            flagsFpNv: return 5'b10000;
            default: return 5'b00000;
        endcase
    endfunction

    // Expected commit lane for an entry, normal or replayed
    function automatic CommitUOp refCommit(SqN s, logic replay);
        CommitUOp r;
        Flags f;
        f = mFlags[s[5:0]];
        r.valid = 1'b1;
        r.sqN = s;
        r.tagDst = mTag[s[5:0]];
        r.isBranch = f inside {flagsBranch, flagsPredTaken, flagsPredNtaken};
        if (replay) begin
            r.nmDst = (f == flagsTrap) ? 5'd0 : mNm[s[5:0]];
            r.compressed = (f == flagsNx);
        end else begin
            r.nmDst = (f inside {flagsTrap, flagsIllegalInstr, flagsAccessFault}) ?
                5'd0 : mNm[s[5:0]];
            r.compressed = mComp[s[5:0]];
        end
        return r;
    endfunction

    function automatic TrapUOp refTrap(SqN s);
        TrapUOp t;
        t.valid = 1'b1;
        t.flags = mFlags[s[5:0]];
        t.tag = mTag[s[5:0]];
        t.sqN = s;
        t.name = mNm[s[5:0]];
        t.fetchOffs = mOffs[s[5:0]];
        t.fetchId = mFid[s[5:0]];
        t.compressed = mComp[s[5:0]];
        return t;
    endfunction

    function automatic Flags wbFlag(int mode);
        logic [2:0] r;
        r = 3'(lcgNext() >> 20);
        case (mode)
            1: begin
                case (r)
                    3'd1: return flagsPredTaken;
                    3'd2: return flagsPredNtaken;
                    3'd3: return flagsFence;
                    3'd4: return flagsIllegalInstr;
                    3'd5: return flagsAccessFault;
                    default: return flagsNone;
                endcase
            end
            2: begin
                case (r)
                    3'd1: return flagsFpNx;
                    3'd2: return flagsFpUf;
                    3'd3: return flagsFpOf;
                    3'd4: return flagsFpDz;
                    3'd5: return flagsFpNv;
                    default: return flagsNone;
                endcase
            end
            default: return (r[1:0] == 2'd0) ? flagsBranch : flagsNone;
        endcase
    endfunction

    task automatic compareCommit(CommitUOp got, CommitUOp exp, int lane);
        if (got !== exp) begin
            $display("Fail %0t comUOp[%0d]: got %h expected %h", $time, lane, got, exp);
            cmpErrors++;
        end
    endtask

    task automatic compareTrap(TrapUOp got, TrapUOp exp);
        if (got !== exp) begin
            $display("Fail %0t trapUOp: got %h expected %h", $time, got, exp);
            cmpErrors++;
        end
    endtask

    task automatic compareFlags(logic [4:0] got, logic [4:0] exp, string name);
        if (got !== exp) begin
            $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
            cmpErrors++;
        end
    endtask

    task automatic compareData(WbData got, WbData exp, string name);
        if (got !== exp) begin
            $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
            cmpErrors++;
        end
    endtask

    task automatic compareSqN(SqN got, SqN exp, string name);
        if (got !== exp) begin
            $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
            cmpErrors++;
        end
    endtask

    task automatic compareFetchId(FetchId got, FetchId exp);
        if (got !== exp) begin
            $display("Fail %0t curFetchId: got %h expected %h", $time, got, exp);
            cmpErrors++;
        end
    endtask

    // Commit monitor, outputs are registered so posedge sees last cycle's values
    always @(posedge clk) begin
        logic stopped;
        logic predSeen;
        logic [4:0] expFp;
        TrapUOp expTrap;
        SqN s;
        if (!rst) begin
            stopped = 1'b0;
            predSeen = 1'b0;
            expFp = '0;
            expTrap = '0;
            for (int i = 0; i < robWidth; i++) begin
                if (comUOp[i].valid && mispredFlush) begin
                    if (replayQ.size() == 0) begin
                        $display("Replay lane %0d has no expected op", i);
                        otherErrors++;
                    end else begin
                        s = replayQ.pop_front();
                        compareCommit(comUOp[i], refCommit(s, 1'b1), i);
                    end
                end else if (comUOp[i].valid) begin
                    if (expQ.size() == 0) begin
                        $display("Commit lane %0d with no op outstanding", i);
                        otherErrors++;
                    end else begin
                        s = expQ.pop_front();
                        if (stopped || (predSeen && mFlags[s[5:0]] != flagsNone)) begin
                            $display("Lane %0d committed after a stopping op", i);
                            otherErrors++;
                        end
                        compareCommit(comUOp[i], refCommit(s, 1'b0), i);
                        expFp |= fpMap(mFlags[s[5:0]]);
                        commits++;
                        mHead = mHead + 7'd1;
                        lastFid = mFid[s[5:0]];
                        fidKnown = 1'b1;
                        if (mFlags[s[5:0]] >= flagsPredTaken) begin
                            expTrap = refTrap(s);
                            lastTrapSq = s;
                            lastTrapFlags = mFlags[s[5:0]];
                            predSeen = 1'b1;
                            stopped = mFlags[s[5:0]] >= flagsFence;
                        end
                    end
                end
            end
            compareTrap(trapUOp, expTrap);
            compareFlags(fpNewFlags, expFp, "fpNewFlags");
            // Head moves with each commit, the youngest renamable sqN is a full buffer ahead
            compareSqN(curSqN, mHead, "curSqN");
            compareSqN(maxSqN, mHead + SqN'(robLength - 1), "maxSqN");
            if (fidKnown) begin
                compareFetchId(curFetchId, lastFid);
            end
            accrued |= expFp;
        end
    end

    // One cycle of stimulus on the falling edge
    task automatic stepCycle(int want, int mode, logic doWb, output int got);
        RenameUOp ops[robWidth];
        logic [robWidth-1:0] vld;
        int k;
        int idx;
        SqN s;
        RenameUOp tmpOp;
        logic tmpV;
        @(negedge clk);
        uopValid = '0;
        branch = '0;
        for (int p = 0; p < wbWidth; p++) begin
            wbUOps[p] = '0;
            if (doWb && pendWb.size() > 0) begin
                idx = int'(lcgNext() % 32'(pendWb.size()));
                s = pendWb[idx];
                pendWb.delete(idx);
                mFlags[s[5:0]] = wbFlag(mMode[s[5:0]]);
                wbUOps[p] = '{1'b1, s, mTag[s[5:0]], mNm[s[5:0]], mFlags[s[5:0]], 1'b0};
            end
        end
        got = want > robWidth ? robWidth : want;
        if (expQ.size() + got > maxInFlight) begin
            got = maxInFlight - expQ.size();
            got = got < 0 ? 0 : got;
        end
        vld = '0;
        for (int i = 0; i < robWidth; i++) begin
            ops[i] = '0;
            if (i < got) begin
                s = nextSq;
                nextSq = nextSq + 7'd1;
                ops[i].sqN = s;
                ops[i].tagDst = Tag'(lcgNext() >> 9);
                ops[i].nmDst = RegNm'(lcgNext() >> 11);
                ops[i].fetchId = FetchId'(lcgNext() >> 13);
                ops[i].fetchOffs = FetchOff'(lcgNext() >> 15);
                ops[i].compressed = 1'(lcgNext() >> 31);
                k = int'((lcgNext() >> 16) % 8);
                ops[i].fu = (mode == 1 && k == 0) ? fuTrap : (k == 1 ? fuRn : fuExec);
                vld[i] = 1'b1;
                mTag[s[5:0]] = ops[i].tagDst;
                mNm[s[5:0]] = ops[i].nmDst;
                mFid[s[5:0]] = ops[i].fetchId;
                mOffs[s[5:0]] = ops[i].fetchOffs;
                mComp[s[5:0]] = ops[i].compressed;
                mMode[s[5:0]] = mode;
                mFlags[s[5:0]] = ops[i].fu == fuRn ? flagsNone :
                    (ops[i].fu == fuTrap ? flagsTrap : flagsNx);
                expQ.push_back(s);
                if (ops[i].fu == fuExec) begin
                    pendWb.push_back(s);
                end
            end
        end
        // Shuffle lanes
        for (int i = robWidth - 1; i > 0; i--) begin
            k = int'((lcgNext() >> 8) % 32'(i + 1));
            tmpOp = ops[i];
            ops[i] = ops[k];
            ops[k] = tmpOp;
            tmpV = vld[i];
            vld[i] = vld[k];
            vld[k] = tmpV;
        end
        for (int i = 0; i < robWidth; i++) begin
            uop[i] = ops[i];
        end
        uopValid = vld;
    endtask

    task automatic issueOps(int n, int mode);
        int got;
        while (n > 0) begin
            stepCycle(n, mode, 1'b1, got);
            n -= got;
        end
    endtask

    task automatic drain();
        int got;
        while (expQ.size() > 0 || pendWb.size() > 0) begin
            stepCycle(0, 0, 1'b1, got);
        end
    endtask

    task automatic csrAccess(logic we, CsrAddr adr, WbData d, output WbData q);
        int got;
        stepCycle(0, 0, 1'b0, got);
        wbReq = '{1'b1, 1'b1, we, adr, d};
        do begin
            stepCycle(0, 0, 1'b0, got);
        end while (!wbRsp.ack);
        q = wbRsp.datR;
        wbReq = '0;
    endtask

    initial begin
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, commits stalled", cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        WbData q;
        SqN brSq;
        SqN keep[$];
        int got;
        rst = 1'b1;
        uopValid = '0;
        branch = '0;
        wbReq = '0;
        for (int i = 0; i < robWidth; i++) begin
            uop[i] = '0;
            wbUOps[i] = '0;
        end
        lcgState = 32'h0c057036;
        nextSq = '0;
        mHead = '0;
        lastFid = '0;
        fidKnown = 1'b0;
        accrued = '0;
        commits = 0;
        cycles = 0;
        cmpErrors = 0;
        otherErrors = 0;
        lastTrapSq = '0;
        lastTrapFlags = flagsNone;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Out-of-order writeback
        issueOps(200, 0);
        drain();

        // Traps, fences and predicted branches
        issueOps(60, 1);
        drain();
        csrAccess(1'b0, csrTrapInfo, '0, q);
        compareData(q, {20'd0, lastTrapFlags, 1'b0, lastTrapSq}, "csrTrapInfo");

        // FP flags accrue, then clear on write
        issueOps(60, 2);
        drain();
        csrAccess(1'b0, csrFflags, '0, q);
        compareFlags(q[4:0], accrued, "csrFflags");
        csrAccess(1'b1, csrFflags, '0, q);
        accrued = '0;
        csrAccess(1'b0, csrFflags, '0, q);
        compareData(q, '0, "csrFflags after clear");

        // Mispredict with commit held so the replay window is known
        csrAccess(1'b1, csrCtrl, 32'd0, q);
        issueOps(12, 0);
        stepCycle(0, 0, 1'b1, got);
        stepCycle(0, 0, 1'b0, got);
        brSq = expQ[0] + 7'd5;
        branch = '{1'b1, brSq};
        keep = {};
        foreach (expQ[i]) begin
            if (ageDiff(expQ[i], brSq) <= 0) begin
                keep.push_back(expQ[i]);
                replayQ.push_back(expQ[i]);
            end
        end
        expQ = keep;
        keep = {};
        foreach (pendWb[i]) begin
            if (ageDiff(pendWb[i], brSq) <= 0) begin
                keep.push_back(pendWb[i]);
            end
        end
        pendWb = keep;
        nextSq = brSq + 7'd1;
        while (replayQ.size() > 0) begin
            stepCycle(0, 0, 1'b0, got);
        end
        repeat (3) stepCycle(0, 0, 1'b0, got);
        csrAccess(1'b1, csrCtrl, 32'd1, q);
        issueOps(8, 0);
        drain();

        // Commit enable holds the head
        csrAccess(1'b1, csrCtrl, 32'd0, q);
        issueOps(8, 0);
        repeat (20) stepCycle(0, 0, 1'b1, got);
        if (expQ.size() != 8) begin
            $display("Ops committed while commit was disabled");
            otherErrors++;
        end
        csrAccess(1'b1, csrCtrl, 32'd1, q);
        drain();
        repeat (3) stepCycle(0, 0, 1'b0, got);
        csrAccess(1'b0, csrCommitCount, '0, q);
        compareData(q, WbData'(commits), "csrCommitCount");

        $display("Errors: compare %0d, other %0d, assertion %0d", cmpErrors, otherErrors,
            dut_i.chk_i.failures);
        if (cmpErrors == 0 && otherErrors == 0 && dut_i.chk_i.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* robSubsystem.f */
hw/robPkg.sv
hw/robCsrPkg.sv
hw/rob.sv
hw/robCsr.sv
hw/robTop.sv
tb/robTop_chk.sv
tb/robTb.sv

/* Bender.yml */
package:
  name: robSubsystem

sources:
  - hw/robPkg.sv
  - hw/robCsrPkg.sv
  - hw/rob.sv
  - hw/robCsr.sv
  - hw/robTop.sv
  - target: simulation
    files:
      - tb/robTop_chk.sv
      - tb/robTb.sv
